// File: Makefile
# Verilator flow for the synthesizer voice block

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module synth_top \
		hw/synth_pkg.sv hw/sine_if.sv hw/spi_slave.sv hw/control_unit.sv \
		hw/sine_table_arbiter.sv hw/oscillator.sv hw/mixer.sv \
		hw/i2s_transmitter.sv hw/synth_top.sv

sim:
	verilator --binary --timing -j 0 --top-module tb_synth -f project.f
	./obj_dir/Vtb_synth | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// File: hw/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  synth_pkg::cmd_t             word,
    input  logic                        word_valid,
    output synth_pkg::phase_t           freq [synth_pkg::N_OSC],
    output synth_pkg::amp_t             amp [synth_pkg::N_OSC],
    output synth_pkg::shape_t           shape [synth_pkg::N_OSC],
    output synth_pkg::volume_t          volume,
    output logic [synth_pkg::N_OSC-1:0] phase_clear
);
    import synth_pkg::*;

    field_t field;
    logic   idx;

    // Target and oscillator select
    assign field = field_t'(word[31:30]);
    assign idx   = word[29];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < N_OSC; i++) begin
                freq[i]  <= '0;
                amp[i]   <= '0;
                shape[i] <= SQUARE;
            end
            volume      <= '0;
            phase_clear <= '0;
        end else begin
            phase_clear <= '0;
            if (word_valid) begin
                case (field)
                    FREQ: begin
                        freq[idx]        <= word[23:0];
                        phase_clear[idx] <= 1'b1;   // Restart from phase zero
                    end
                    AMP:    amp[idx]   <= word[15:0];
                    SHAPE:  shape[idx] <= shape_t'(word[1:0]);
                    VOLUME: volume     <= word[7:0];   // Shared by all voices
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/i2s_transmitter.sv
`timescale 1ns/10ps
`default_nettype none

module i2s_transmitter (
    input  logic               clk,
    input  logic               reset,
    input  logic               bit_tick,
    input  synth_pkg::sample_t sample,
    input  logic               sample_valid,
    output logic               sclk,
    output logic               lrclk,
    output logic               sd
);
    import synth_pkg::*;

    i2s_state_t                      state;
    sample_t                         held;      // Latest mixed sample
    logic [2*$bits(sample_t)-1:0]    frame;     // Left then right, MSB first
    logic [5:0]                      bit_cnt;   // Bit slot within the frame
    logic [5:0]                      next_cnt;
    logic                            fall;
    logic                            frame_start;

    // Data and lrclk move on the falling sclk edge
    assign fall        = (state == SHIFT) && bit_tick && sclk;
    assign frame_start = bit_cnt == 6'(2 * $bits(sample_t) - 1);
    assign next_cnt    = frame_start ? '0 : bit_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            sclk    <= 1'b0;
            lrclk   <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= 6'(2 * $bits(sample_t) - 1);   // First fall opens a frame
            frame   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (sample_valid) state <= SHIFT;
                end
                SHIFT: begin
                    if (bit_tick) sclk <= ~sclk;
                    if (fall) begin
                        bit_cnt <= next_cnt;
                        lrclk   <= next_cnt >= 6'($bits(sample_t));    // High on right
                        sd      <= frame[$bits(frame)-1];   // One bit behind lrclk
                        frame   <= frame_start ? {held, held} : {frame[$bits(frame)-2:0], 1'b0};
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            held <= sample;
        end
    end

endmodule

`default_nettype wire

// File: hw/mixer.sv
`timescale 1ns/10ps
`default_nettype none

module mixer (
    input  logic                        clk,
    input  logic                        reset,
    input  synth_pkg::sample_t          voice [synth_pkg::N_OSC],
    input  logic [synth_pkg::N_OSC-1:0] voice_valid,
    input  synth_pkg::volume_t          volume,
    output synth_pkg::sample_t          mix,
    output logic                        mix_valid
);
    import synth_pkg::*;

    sample_t                 voice_q [N_OSC];   // Voices that arrived early
    sample_t                 pick [N_OSC];
    logic [N_OSC-1:0]        seen;
    logic                    all_seen;
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W+8:0] scaled;

    always_comb begin
        sum = '0;
        for (int i = 0; i < N_OSC; i++) begin
            pick[i] = voice_valid[i] ? voice[i] : voice_q[i];
            sum     = sum + pick[i];
        end
        scaled   = (sum * $signed({1'b0, volume})) >>> 8;
        all_seen = &(seen | voice_valid);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seen      <= '0;
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= all_seen;
            seen      <= all_seen ? '0 : (seen | voice_valid);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N_OSC; i++) begin
            if (voice_valid[i]) voice_q[i] <= voice[i];
        end
        if (all_seen) begin
            if (scaled > SAMPLE_MAX)        mix <= sample_t'(SAMPLE_MAX);
            else if (scaled < -SAMPLE_MAX)  mix <= sample_t'(-SAMPLE_MAX);
            else                            mix <= scaled[23:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/oscillator.sv
`timescale 1ns/10ps
`default_nettype none

module oscillator (
    input  logic              clk,
    input  logic              reset,
    input  logic              sample_tick,
    input  synth_pkg::phase_t freq,
    input  synth_pkg::amp_t   amp,
    input  synth_pkg::shape_t shape,
    input  logic              phase_clear,
    sine_if.osc               tbl,
    output synth_pkg::sample_t out,
    output logic              out_valid
);
    import synth_pkg::*;

    phase_t             phase;
    phase_t             tick_phase;     // Phase this tick's sample is taken from
    logic [22:0]        folded;
    sample_t            raw_now;
    sample_t            raw_q;
    sample_t            raw_sel;
    logic               sine_neg;       // Lower half of the sine cycle
    logic               valid_q;
    logic signed [40:0] prod;

    assign tick_phase = phase_clear ? '0 : phase + freq;

    always_comb begin
        folded = tick_phase[23] ? ~tick_phase[22:0] : tick_phase[22:0];
        case (shape)
            SQUARE:   raw_now = tick_phase[23] ? sample_t'(-SAMPLE_MAX) : sample_t'(SAMPLE_MAX);
            SAW:      raw_now = sample_t'(tick_phase);
            TRIANGLE: raw_now = sample_t'({~folded[22], folded[21:0], 1'b0});  // Recentred
            default:  raw_now = '0;     // Sine comes back from the table
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase   <= '0;
            tbl.req <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= sample_tick && (shape != SINE);
            if (sample_tick || phase_clear) begin
                phase <= tick_phase;
            end
            if (tbl.ack) begin
                tbl.req <= 1'b0;
            end
            if (sample_tick && shape == SINE) begin
                tbl.req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_tick) begin
            raw_q    <= raw_now;
            sine_neg <= tick_phase[23];
            // Second and fourth quarters read the table backwards
            tbl.addr <= tick_phase[22] ? ~tick_phase[21:16] : tick_phase[21:16];
        end
    end

    // Table data is only held for the ack cycle, so it bypasses raw_q
    assign raw_sel   = tbl.ack ? (sine_neg ? -tbl.data : tbl.data) : raw_q;
    assign prod      = raw_sel * $signed({1'b0, amp});
    assign out       = prod[39:16];
    assign out_valid = valid_q | tbl.ack;

endmodule

`default_nettype wire

// File: hw/sine_if.sv
`timescale 1ns/10ps
`default_nettype none

// One oscillator's path into the shared quarter-wave table
interface sine_if;
    import synth_pkg::*;

    logic       req;    // Held by the oscillator until ack
    logic [5:0] addr;   // Quarter-wave address
    logic       ack;    // One-cycle strobe from the arbiter
    sample_t    data;   // Valid while ack is high

    modport osc (output req, output addr, input ack, input data);
    modport arb (input req, input addr, output ack, output data);

endinterface

`default_nettype wire

// File: hw/sine_table_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module sine_table_arbiter #(
    parameter int N_PORTS = synth_pkg::N_OSC
) (
    input logic clk,
    input logic reset,
    sine_if.arb port [N_PORTS]
);
    import synth_pkg::*;

    typedef logic [$clog2(N_PORTS)-1:0] port_idx_t;

    logic [N_PORTS-1:0] req_vec;
    logic [N_PORTS-1:0] req_eff;
    logic [N_PORTS-1:0] ack_q;
    logic [5:0]         addr_vec [N_PORTS];
    port_idx_t          ptr;            // Highest priority this cycle
    port_idx_t          grant_idx;
    logic               grant_valid;
    logic [3:0]         rom_idx;
    sample_t            rom_data;
    sample_t            data_q;

    for (genvar i = 0; i < N_PORTS; i++) begin : g_port
        assign req_vec[i]   = port[i].req;
        assign addr_vec[i]  = port[i].addr;
        assign port[i].ack  = ack_q[i];
        assign port[i].data = data_q;
    end

    // A port still sees its ack this cycle, so its req is stale
    assign req_eff = req_vec & ~ack_q;

    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant_idx   = ptr;
        for (int k = 0; k < N_PORTS; k++) begin
            cand = (int'(ptr) + k) % N_PORTS;
            if (!grant_valid && req_eff[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = port_idx_t'(cand);
            end
        end
    end

    assign rom_idx = addr_vec[grant_idx][5:2];

    // Quarter sine, entry i is sin(i * 6 deg) at full scale
    always_comb begin
        case (rom_idx)
            4'd0:    rom_data = 24'sd0;
            4'd1:    rom_data = 24'sd876848;
            4'd2:    rom_data = 24'sd1744089;
            4'd3:    rom_data = 24'sd2592222;
            4'd4:    rom_data = 24'sd3411954;
            4'd5:    rom_data = 24'sd4194304;
            4'd6:    rom_data = 24'sd4930699;
            4'd7:    rom_data = 24'sd5613074;
            4'd8:    rom_data = 24'sd6233950;
            4'd9:    rom_data = 24'sd6786526;
            4'd10:   rom_data = 24'sd7264747;
            4'd11:   rom_data = 24'sd7663374;
            4'd12:   rom_data = 24'sd7978039;
            4'd13:   rom_data = 24'sd8205296;
            4'd14:   rom_data = 24'sd8342653;
            default: rom_data = sample_t'(SAMPLE_MAX);  // Peak
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= '0;
            ptr   <= '0;
        end else begin
            ack_q <= '0;
            if (grant_valid) begin
                ack_q[grant_idx] <= 1'b1;
                ptr <= (grant_idx == port_idx_t'(N_PORTS - 1)) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            data_q <= rom_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/spi_slave.sv
`timescale 1ns/10ps
`default_nettype none

module spi_slave (
    input  logic              clk,
    input  logic              reset,
    input  logic              sclk,
    input  logic              mosi,
    input  logic              csn,
    output logic              miso,
    output synth_pkg::cmd_t   word,
    output logic              word_valid
);
    import synth_pkg::*;

    logic [2:0] sclk_sync;      // Two sync stages plus one for edge detect
    logic [2:0] csn_sync;
    logic [1:0] mosi_sync;
    logic       sclk_rise;
    logic       csn_rise;
    logic       word_done;
    logic [5:0] bit_cnt;        // Saturates one past a full word
    cmd_t       shreg;

    assign miso      = 1'b0;    // No read-back
    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign csn_rise  = csn_sync[1] & ~csn_sync[2];
    assign word_done = csn_rise && (bit_cnt == 6'($bits(cmd_t)));

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_sync  <= '0;
            csn_sync   <= '1;   // Bus idles deselected
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            sclk_sync  <= {sclk_sync[1:0], sclk};
            csn_sync   <= {csn_sync[1:0], csn};
            word_valid <= word_done;
            if (csn_sync[1]) begin
                bit_cnt <= '0;
            end else if (sclk_rise && bit_cnt <= 6'($bits(cmd_t))) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], mosi};  // Same delay as sclk_sync[1]
        if (sclk_rise && !csn_sync[1]) begin
            shreg <= {shreg[$bits(cmd_t)-2:0], mosi_sync[1]};
        end
        if (word_done) begin
            word <= shreg;
        end
    end

endmodule

`default_nettype wire

// File: hw/synth_pkg.sv
`default_nettype none

package synth_pkg;

    // Audio and control word types
    typedef logic signed [23:0] sample_t;   // Signed audio sample
    typedef logic [23:0]        phase_t;    // Phase and frequency increment
    typedef logic [15:0]        amp_t;      // All ones is full scale
    typedef logic [7:0]         volume_t;   // 255 is close to unity
    typedef logic [31:0]        cmd_t;      // SPI command word

    // Waveform selection per oscillator
    typedef enum logic [1:0] {
        SQUARE,
        SAW,
        TRIANGLE,
        SINE
    } shape_t;

    // Command target, bits 31:30 of a command word
    typedef enum logic [1:0] {
        FREQ,
        AMP,
        SHAPE,
        VOLUME
    } field_t;

    typedef enum logic {
        IDLE,   // Waiting for the first mixed sample
        SHIFT   // Clocking out frames
    } i2s_state_t;

    localparam int N_OSC      = 2;
    localparam int SAMPLE_DIV = 384;        // Clocks per sample
    localparam int BIT_DIV    = 8;          // Clocks per I2S bit strobe
    localparam int SAMPLE_MAX = 8388607;

    // Voice sum width, one growth bit per doubling of voices
    localparam int SUM_W = 24 + $clog2(N_OSC);

endpackage

`default_nettype wire

// File: hw/synth_top.sv
`timescale 1ns/10ps
`default_nettype none

module synth_top (
    input  logic clk,
    input  logic reset,
    input  logic spi_sclk,
    input  logic spi_mosi,
    input  logic spi_csn,
    output logic spi_miso,
    output logic i2s_sclk,
    output logic i2s_lrclk,
    output logic i2s_sd
);
    import synth_pkg::*;

    logic [$clog2(SAMPLE_DIV)-1:0] sample_cnt;
    logic [$clog2(BIT_DIV)-1:0]    bit_cnt;
    logic                          sample_tick;
    logic                          bit_tick;
    cmd_t                          word;
    logic                          word_valid;
    phase_t                        freq [N_OSC];
    amp_t                          amp [N_OSC];
    shape_t                        shape [N_OSC];
    volume_t                       volume;
    logic [N_OSC-1:0]              phase_clear;
    sample_t                       voice [N_OSC];
    logic [N_OSC-1:0]              voice_valid;
    sample_t                       mix;
    logic                          mix_valid;

    sine_if tbl [N_OSC] ();

    // Sample and bit strobes, both derived from clk
    assign sample_tick = sample_cnt == SAMPLE_DIV - 1;
    assign bit_tick    = bit_cnt == BIT_DIV - 1;

    always_ff @(posedge clk) begin
        if (reset) begin
            sample_cnt <= '0;
            bit_cnt    <= '0;
        end else begin
            sample_cnt <= sample_tick ? '0 : sample_cnt + 1'b1;
            bit_cnt    <= bit_tick ? '0 : bit_cnt + 1'b1;
        end
    end

    spi_slave u_spi (
        .clk(clk), .reset(reset),
        .sclk(spi_sclk), .mosi(spi_mosi), .csn(spi_csn), .miso(spi_miso),
        .word(word), .word_valid(word_valid)
    );

    control_unit u_ctrl (
        .clk(clk), .reset(reset), .word(word), .word_valid(word_valid),
        .freq(freq), .amp(amp), .shape(shape), .volume(volume),
        .phase_clear(phase_clear)
    );

    sine_table_arbiter #(.N_PORTS(N_OSC)) u_arb (
        .clk(clk), .reset(reset), .port(tbl)
    );

    for (genvar i = 0; i < N_OSC; i++) begin : g_osc
        oscillator u_osc (
            .clk(clk), .reset(reset), .sample_tick(sample_tick),
            .freq(freq[i]), .amp(amp[i]), .shape(shape[i]),
            .phase_clear(phase_clear[i]), .tbl(tbl[i]),
            .out(voice[i]), .out_valid(voice_valid[i])
        );
    end

    mixer u_mix (
        .clk(clk), .reset(reset), .voice(voice), .voice_valid(voice_valid),
        .volume(volume), .mix(mix), .mix_valid(mix_valid)
    );

    i2s_transmitter u_i2s (
        .clk(clk), .reset(reset), .bit_tick(bit_tick),
        .sample(mix), .sample_valid(mix_valid),
        .sclk(i2s_sclk), .lrclk(i2s_lrclk), .sd(i2s_sd)
    );

endmodule

`default_nettype wire

// File: project.f
hw/synth_pkg.sv
hw/sine_if.sv
hw/spi_slave.sv
hw/control_unit.sv
hw/sine_table_arbiter.sv
hw/oscillator.sv
hw/mixer.sv
hw/i2s_transmitter.sv
hw/synth_top.sv
tests/tb_synth.sv

// File: tests/tb_synth.sv
`timescale 1ns/10ps
`default_nettype none

module tb_synth;
    import synth_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int N_ROWS      = 9;
    localparam int MAX_CMDS    = 5;
    localparam int FRAME_CLKS  = 2 * SAMPLE_DIV;   // 48 bits of 16 clocks
    // Four frames per row, three more for SPI traffic, plus reset
    localparam int WATCHDOG_NS = N_ROWS * 7 * FRAME_CLKS * CLK_NS + 20000;

    localparam int K_VALUE = 0;     // Left sample equals expected
    localparam int K_DIFF  = 1;     // Difference of two frames
    localparam int K_SINE  = 2;     // Quarter-rate sine pair
    localparam int K_RATE  = 3;     // Mixed samples per frame

    logic clk = 1'b0;
    logic reset;
    logic spi_sclk;
    logic spi_mosi;
    logic spi_csn;
    logic spi_miso;
    logic i2s_sclk;
    logic i2s_lrclk;
    logic i2s_sd;

    string   names [N_ROWS];
    int      kinds [N_ROWS];
    int      n_cmds [N_ROWS];
    cmd_t    cmds [N_ROWS][MAX_CMDS];
    int      cmd_bits [N_ROWS][MAX_CMDS];
    sample_t exp_vals [N_ROWS];

    int      errors = 0;
    int      checks = 0;
    int      frame_count = 0;
    int      valid_count = 0;
    int      slot = 100;
    logic    prev_lr = 1'b0;
    sample_t left_shift;
    sample_t left_sample;

    always #(CLK_NS / 2) clk = ~clk;

    synth_top u_dut (
        .clk(clk), .reset(reset),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_csn(spi_csn),
        .spi_miso(spi_miso),
        .i2s_sclk(i2s_sclk), .i2s_lrclk(i2s_lrclk), .i2s_sd(i2s_sd)
    );

    // I2S receiver, left channel only; slot 0 carries the delayed bit
    always @(posedge i2s_sclk) begin
        if (prev_lr && !i2s_lrclk) slot = 0;
        else if (slot < 100) slot = slot + 1;
        prev_lr = i2s_lrclk;
        if (slot >= 1 && slot <= 24) left_shift = {left_shift[22:0], i2s_sd};
        if (slot == 24) begin
            left_sample = left_shift;
            frame_count = frame_count + 1;
        end
    end

    always @(posedge clk) begin
        if (u_dut.mix_valid) valid_count = valid_count + 1;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    function automatic cmd_t make_cmd(field_t f, bit idx, logic [23:0] payload);
        return {f, idx, 5'b0, payload};
    endfunction

    // Raw shape times amp, upper 24 bits of the product
    function automatic longint voice_out(longint raw, longint amp);
        return (raw * amp) >>> 16;
    endfunction

    // Volume scaling with saturation to the sample range
    function automatic sample_t mix_out(longint sum, longint vol);
        longint s;
        s = (sum * vol) >>> 8;
        if (s > SAMPLE_MAX) s = SAMPLE_MAX;
        if (s < -SAMPLE_MAX) s = -SAMPLE_MAX;
        return sample_t'(s);
    endfunction

    task automatic set_row(int r, string name, int kind, sample_t value);
        names[r]    = name;
        kinds[r]    = kind;
        exp_vals[r] = value;
        n_cmds[r]   = 0;
    endtask

    task automatic add_command(int r, cmd_t c, int nbits);
        cmds[r][n_cmds[r]]     = c;
        cmd_bits[r][n_cmds[r]] = nbits;
        n_cmds[r]              = n_cmds[r] + 1;
    endtask

    task automatic build_table();
        longint pk;
        pk = voice_out(SAMPLE_MAX, 65535);
        set_row(0, "reset", K_VALUE, '0);
        set_row(1, "square_one", K_VALUE, mix_out(pk, 255));
        add_command(1, make_cmd(AMP, 0, 24'hffff), 32);
        add_command(1, make_cmd(VOLUME, 0, 24'd255), 32);
        set_row(2, "square_two", K_VALUE, mix_out(2 * pk, 255));
        add_command(2, make_cmd(AMP, 1, 24'hffff), 32);
        // Two samples per frame, so the phase step is twice freq
        set_row(3, "saw_step", K_DIFF, mix_out(voice_out(2 * 1024, 32768), 128));
        add_command(3, make_cmd(AMP, 1, 24'h0), 32);
        add_command(3, make_cmd(VOLUME, 0, 24'd128), 32);
        add_command(3, make_cmd(AMP, 0, 24'h8000), 32);
        add_command(3, make_cmd(SHAPE, 0, 24'(SAW)), 32);
        add_command(3, make_cmd(FREQ, 0, 24'd1024), 32);
        set_row(4, "sine_still", K_VALUE, '0);
        add_command(4, make_cmd(SHAPE, 0, 24'(SINE)), 32);
        add_command(4, make_cmd(FREQ, 0, 24'h0), 32);
        set_row(5, "sine_quarter", K_SINE, '0);
        add_command(5, make_cmd(FREQ, 0, 24'h400000), 32);
        set_row(6, "square_half", K_VALUE, mix_out(voice_out(SAMPLE_MAX, 32768), 128));
        add_command(6, make_cmd(SHAPE, 0, 24'(SQUARE)), 32);
        add_command(6, make_cmd(FREQ, 0, 24'h0), 32);
        set_row(7, "short_write", K_VALUE, exp_vals[6]);
        add_command(7, make_cmd(VOLUME, 0, 24'd255), 16);
        set_row(8, "sine_both", K_RATE, 24'sd2);
        add_command(8, make_cmd(SHAPE, 0, 24'(SINE)), 32);
        add_command(8, make_cmd(SHAPE, 1, 24'(SINE)), 32);
        add_command(8, make_cmd(AMP, 1, 24'h8000), 32);
        add_command(8, make_cmd(FREQ, 0, 24'h400000), 32);
        add_command(8, make_cmd(FREQ, 1, 24'h400000), 32);
    endtask

    // SPI mode 0, 40 ns sclk, MSB first
    task automatic spi_write(cmd_t c, int nbits);
        @(negedge clk);
        spi_csn = 1'b0;
        repeat (5) @(negedge clk);
        for (int b = 0; b < nbits; b++) begin
            spi_mosi = c[31 - b];
            repeat (5) @(negedge clk);
            check_bit("spi_miso", spi_miso, 1'b0);   // No read-back
            spi_sclk = 1'b1;
            repeat (5) @(negedge clk);
            spi_sclk = 1'b0;
        end
        repeat (5) @(negedge clk);
        spi_csn = 1'b1;
        repeat (10) @(negedge clk);
    endtask

    task automatic wait_frames(int n);
        int target;
        target = frame_count + n;
        wait (frame_count >= target);
    endtask

    task automatic check_sample(string name, sample_t actual, sample_t expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, name,
                     actual, expected);
        end
    endtask

    task automatic check_count(string name, int actual, int expected);
        checks = checks + 1;
        if (actual != expected) begin
            errors = errors + 1;
            $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, name,
                     actual, expected);
        end
    endtask

    task automatic check_bit(string name, logic actual, logic expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Mismatch at %0d ns: %s is %b, expected %b", $time, name,
                     actual, expected);
        end
    endtask

    task automatic run_row(int r);
        sample_t a;
        sample_t pos;
        sample_t neg;
        int      c0;
        int      errs_before;
        errs_before = errors;
        for (int k = 0; k < n_cmds[r]; k++) spi_write(cmds[r][k], cmd_bits[r][k]);
        wait_frames(2);
        case (kinds[r])
            K_VALUE: begin
                wait_frames(1);
                check_sample("left", left_sample, exp_vals[r]);
            end
            K_DIFF: begin
                wait_frames(1);
                a = left_sample;
                wait_frames(1);
                check_sample("left_diff", left_sample - a, exp_vals[r]);
            end
            K_SINE: begin
                pos = mix_out(voice_out(SAMPLE_MAX, 32768), 128);
                neg = mix_out(voice_out(-SAMPLE_MAX, 32768), 128);
                wait_frames(1);
                a = left_sample;
                wait_frames(1);
                // Each frame lands on a peak, the sign alternating
                if (a == pos) check_sample("left_trough", left_sample, neg);
                else begin
                    check_sample("left_trough", a, neg);
                    check_sample("left_peak", left_sample, pos);
                end
            end
            default: begin
                wait_frames(1);
                c0 = valid_count;
                wait_frames(1);
                check_count("mix_valid_per_frame", valid_count - c0, int'(exp_vals[r]));
            end
        endcase
        $display("Row %0d %s %s", r, names[r], (errors == errs_before) ? "passed" : "failed");
    endtask

    initial begin
        reset    = 1'b1;
        spi_sclk = 1'b0;
        spi_mosi = 1'b0;
        spi_csn  = 1'b1;
        build_table();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < N_ROWS; r++) run_row(r);
        $display("Rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
